// File: list.f
hdl/wh_test_pkg.sv
hdl/one_slot_fifo.sv
hdl/test_data_gen.sv
hdl/test_node_master.sv
hdl/loopback_node.sv
hdl/test_ctrl_regs.sv
hdl/wh_test_top.sv
tests/wh_test_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= wh_test_tb
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0
PASS_MSG  ?= Test completed successfully

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the simulation and search the log"
	@echo "  clean  remove the build directory and the log"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS PASS_MSG"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "Simulation did not pass, see $(LOG)"; exit 1)
	@echo "Simulation passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: tests/wh_test_tb.sv
`timescale 1ns/1ps

module wh_test_tb
  import wh_test_pkg::*;
();

  localparam logic [cord_width_c-1:0] loop_cord_c = 6'h11;
  localparam int num_steps_c = 4;

  logic                  clk_i = 1'b0;
  logic                  reset_i;
  logic                  host_we_i;
  logic                  host_re_i;
  logic [2:0]            host_addr_i;
  logic [31:0]           host_wdata_i;
  logic [31:0]           host_rdata_o;
  logic [num_nets_c-1:0] error_o;
  logic [num_nets_c-1:0] drop_o;

  // Step table of name, enables, destination, run cycles and whether flits come back
  string step_name [num_steps_c] = '{"both_loop", "net0_loop", "net1_drop", "both_drop"};
  logic [num_nets_c-1:0] step_en [num_steps_c] = '{2'b11, 2'b01, 2'b10, 2'b11};
  logic [cord_width_c-1:0] step_dest [num_steps_c] = '{loop_cord_c, loop_cord_c, 6'h05, 6'h2a};
  int step_run [num_steps_c] = '{80, 50, 40, 50};
  logic step_loop [num_steps_c] = '{1'b1, 1'b1, 1'b0, 1'b0};

  int          drop_cnt [num_nets_c] = '{0, 0};
  int          cycle_cnt = 0;
  int          cycle_limit = 0;
  logic [31:0] sent_now [num_nets_c];
  logic [31:0] recv_now [num_nets_c];

  wh_test_top #(
    .num_channels_p (2),
    .channel_width_p(8),
    .loop_cord_p    (loop_cord_c)
  ) wh_test_top_i (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .host_we_i   (host_we_i),
    .host_re_i   (host_re_i),
    .host_addr_i (host_addr_i),
    .host_wdata_i(host_wdata_i),
    .host_rdata_o(host_rdata_o),
    .error_o     (error_o),
    .drop_o      (drop_o)
  );

  always #2 clk_i = ~clk_i;

  task automatic compare(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
    if (actual !== expected)
    begin
      $display("FAIL %s expected %0h actual %0h", name, expected, actual);
      $display("Test failed");
      $fatal(1, "mismatch in %s", name);
    end
  endtask

  task automatic host_write(input reg_addr_e addr, input logic [31:0] data);
    @(negedge clk_i);
    host_we_i    = 1'b1;
    host_addr_i  = addr;
    host_wdata_i = data;
    @(negedge clk_i);
    host_we_i = 1'b0;
  endtask

  // Read data is registered, so it is ready one cycle after the strobe
  task automatic host_read(input reg_addr_e addr, output logic [31:0] data);
    @(negedge clk_i);
    host_re_i   = 1'b1;
    host_addr_i = addr;
    @(negedge clk_i);
    host_re_i = 1'b0;
    data      = host_rdata_o;
  endtask

  // One drop_o cycle per discarded flit
  always @(negedge clk_i)
  begin
    if (!reset_i)
    begin
      for (int i = 0; i < num_nets_c; i++)
        if (drop_o[i])
          drop_cnt[i] = drop_cnt[i] + 1;
      compare("error_o stays low", 32'd0, 32'(error_o));
    end
  end

  always @(posedge clk_i)
  begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_limit > 0 && cycle_cnt >= cycle_limit)
    begin
      $display("The run did not finish within %0d cycles", cycle_limit);
      $display("Test failed");
      $fatal(1, "timeout");
    end
  end

  initial
  begin
    logic [31:0] rd;
    logic [31:0] sent_base [num_nets_c];
    logic [31:0] recv_base [num_nets_c];
    int          drop_base [num_nets_c];
    logic [31:0] sent_d;
    logic [31:0] recv_d;
    logic [31:0] drop_d;
    logic        done;

    reset_i      = 1'b1;
    host_we_i    = 1'b0;
    host_re_i    = 1'b0;
    host_addr_i  = 3'd0;
    host_wdata_i = 32'd0;
    cycle_limit  = 200;
    for (int s = 0; s < num_steps_c; s++)
      cycle_limit += 2 * step_run[s];

    repeat (8) @(negedge clk_i);
    reset_i = 1'b0;

    for (int a = 0; a <= int'(REG_ERROR); a++)
    begin
      host_read(reg_addr_e'(a), rd);
      compare($sformatf("reset value of register %0d", a), 32'd0, rd);
    end
    compare("drop_o after reset", 32'd0, 32'(drop_cnt[0] + drop_cnt[1]));

    for (int s = 0; s < num_steps_c; s++)
    begin
      for (int i = 0; i < num_nets_c; i++)
      begin
        host_read(reg_addr_e'(int'(REG_SENT0) + i), sent_base[i]);
        host_read(reg_addr_e'(int'(REG_RECV0) + i), recv_base[i]);
        drop_base[i] = drop_cnt[i];
      end
      host_write(REG_DEST, 32'(step_dest[s]));
      host_read(REG_DEST, rd);
      compare({step_name[s], " dest readback"}, 32'(step_dest[s]), rd);
      host_write(REG_ENABLE, 32'(step_en[s]));
      repeat (step_run[s]) @(negedge clk_i);
      host_write(REG_ENABLE, 32'd0);

      // Sent is frozen once the enables are off
      for (int i = 0; i < num_nets_c; i++)
        host_read(reg_addr_e'(int'(REG_SENT0) + i), sent_now[i]);

      // Drained when every sent flit came back or was dropped
      done = 1'b0;
      while (!done)
      begin
        done = 1'b1;
        for (int i = 0; i < num_nets_c; i++)
        begin
          host_read(reg_addr_e'(int'(REG_RECV0) + i), recv_now[i]);
          if (recv_now[i] - recv_base[i] + 32'(drop_cnt[i] - drop_base[i]) <
              sent_now[i] - sent_base[i])
            done = 1'b0;
        end
      end

      for (int i = 0; i < num_nets_c; i++)
      begin
        sent_d = sent_now[i] - sent_base[i];
        recv_d = recv_now[i] - recv_base[i];
        drop_d = 32'(drop_cnt[i] - drop_base[i]);
        compare($sformatf("%s net %0d sent rises", step_name[s], i),
                32'(step_en[s][i]), 32'(sent_d != 0));
        compare($sformatf("%s net %0d received", step_name[s], i),
                (step_en[s][i] && step_loop[s]) ? sent_d : 32'd0, recv_d);
        compare($sformatf("%s net %0d drops", step_name[s], i),
                (step_en[s][i] && !step_loop[s]) ? sent_d : 32'd0, drop_d);
      end
      host_read(REG_ERROR, rd);
      compare({step_name[s], " error flags"}, 32'd0, rd);
    end

    // Counters are read-only from the host
    host_read(REG_SENT0, sent_base[0]);
    host_write(REG_SENT0, 32'hdead_beef);
    host_read(REG_SENT0, rd);
    compare("sent0 after host write", sent_base[0], rd);
    host_read(REG_RECV1, recv_base[1]);
    host_write(REG_RECV1, 32'h1234_5678);
    host_read(REG_RECV1, rd);
    compare("recv1 after host write", recv_base[1], rd);

    $display("Test completed successfully");
    $finish;
  end

endmodule

// File: hdl/wh_test_top.sv
`timescale 1ns/1ps

module wh_test_top
  import wh_test_pkg::*;
#(
  parameter int                      num_channels_p  = 2,
  parameter int                      channel_width_p = 8,
  parameter logic [cord_width_c-1:0] loop_cord_p     = 6'h11
)
(
  input  logic                  clk_i,
  input  logic                  reset_i,

  input  logic                  host_we_i,
  input  logic                  host_re_i,
  input  logic [2:0]            host_addr_i,
  input  logic [31:0]           host_wdata_i,
  output logic [31:0]           host_rdata_o,

  output logic [num_nets_c-1:0] error_o,
  output logic [num_nets_c-1:0] drop_o
);

  logic [num_nets_c-1:0]                   en;
  logic [cord_width_c-1:0]                 dest_cord;
  logic [num_nets_c-1:0][31:0]             sent;
  logic [num_nets_c-1:0][31:0]             received;

  // Master to loopback
  logic [num_nets_c-1:0]                   fwd_v;
  logic [num_nets_c-1:0][flit_width_c-1:0] fwd_data;
  logic [num_nets_c-1:0]                   fwd_ready;

  // Loopback back to master
  logic [num_nets_c-1:0]                   rev_v;
  logic [num_nets_c-1:0][flit_width_c-1:0] rev_data;
  logic [num_nets_c-1:0]                   rev_ready;

  test_ctrl_regs regs_i (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .host_we_i   (host_we_i),
    .host_re_i   (host_re_i),
    .host_addr_i (host_addr_i),
    .host_wdata_i(host_wdata_i),
    .host_rdata_o(host_rdata_o),
    .en_o        (en),
    .dest_cord_o (dest_cord),
    .sent_i      (sent),
    .received_i  (received),
    .error_i     (error_o)
  );

  test_node_master #(
    .num_channels_p (num_channels_p),
    .channel_width_p(channel_width_p)
  ) master_i (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .en_i       (en),
    .dest_cord_i(dest_cord),
    .error_o    (error_o),
    .sent_o     (sent),
    .received_o (received),
    .fwd_v_o    (fwd_v),
    .fwd_data_o (fwd_data),
    .fwd_ready_i(fwd_ready),
    .rev_v_i    (rev_v),
    .rev_data_i (rev_data),
    .rev_ready_o(rev_ready)
  );

  loopback_node #(
    .loop_cord_p(loop_cord_p)
  ) loopback_i (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .in_v_i     (fwd_v),
    .in_data_i  (fwd_data),
    .in_ready_o (fwd_ready),
    .out_v_o    (rev_v),
    .out_data_o (rev_data),
    .out_ready_i(rev_ready),
    .drop_o     (drop_o)
  );

endmodule

// File: hdl/test_ctrl_regs.sv
`timescale 1ns/1ps

module test_ctrl_regs
  import wh_test_pkg::*;
(
  input  logic                        clk_i,
  input  logic                        reset_i,

  input  logic                        host_we_i,
  input  logic                        host_re_i,
  input  logic [2:0]                  host_addr_i,
  input  logic [31:0]                 host_wdata_i,
  output logic [31:0]                 host_rdata_o,

  output logic [num_nets_c-1:0]       en_o,
  output logic [cord_width_c-1:0]     dest_cord_o,
  input  logic [num_nets_c-1:0][31:0] sent_i,
  input  logic [num_nets_c-1:0][31:0] received_i,
  input  logic [num_nets_c-1:0]       error_i
);

  reg_addr_e                   addr;
  logic [num_nets_c-1:0]       en_r;
  logic [cord_width_c-1:0]     dest_r;
  logic [31:0]                 rd_val;
  logic [31:0]                 rdata_r;

  assign addr = reg_addr_e'(host_addr_i);

  // Status words are read-only
  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      en_r   <= '0;
      dest_r <= '0;
    end
    else if (host_we_i)
    begin
      case (addr)
        REG_ENABLE: en_r   <= host_wdata_i[num_nets_c-1:0];
        REG_DEST:   dest_r <= host_wdata_i[cord_width_c-1:0];
        default:    ;
      endcase
    end
  end

  always_comb
  begin
    case (addr)
      REG_ENABLE: rd_val = 32'(en_r);
      REG_DEST:   rd_val = 32'(dest_r);
      REG_SENT0:  rd_val = sent_i[0];
      REG_SENT1:  rd_val = sent_i[1];
      REG_RECV0:  rd_val = received_i[0];
      REG_RECV1:  rd_val = received_i[1];
      REG_ERROR:  rd_val = 32'(error_i);
      default:    rd_val = '0;
    endcase
  end

  // One-cycle read latency
  always_ff @(posedge clk_i)
  begin
    if (reset_i)
      rdata_r <= '0;
    else if (host_re_i)
      rdata_r <= rd_val;
  end

  assign host_rdata_o = rdata_r;
  assign en_o         = en_r;
  assign dest_cord_o  = dest_r;

endmodule

// File: hdl/loopback_node.sv
`timescale 1ns/1ps

module loopback_node
  import wh_test_pkg::*;
#(
  parameter logic [cord_width_c-1:0] loop_cord_p = 6'h11
)
(
  input  logic                                    clk_i,
  input  logic                                    reset_i,

  input  logic [num_nets_c-1:0]                   in_v_i,
  input  logic [num_nets_c-1:0][flit_width_c-1:0] in_data_i,
  output logic [num_nets_c-1:0]                   in_ready_o,

  output logic [num_nets_c-1:0]                   out_v_o,
  output logic [num_nets_c-1:0][flit_width_c-1:0] out_data_o,
  input  logic [num_nets_c-1:0]                   out_ready_i,

  output logic [num_nets_c-1:0]                   drop_o
);

  for (genvar i = 0; i < num_nets_c; i++)
  begin : g_net
    logic                    in_v;
    logic [flit_width_c-1:0] in_data;
    logic                    in_yumi;
    logic                    match;
    logic                    out_slot_ready;

    one_slot_fifo #(.width_p(flit_width_c)) in_fifo (
      .clk_i  (clk_i),
      .reset_i(reset_i),
      .v_i    (in_v_i[i]),
      .data_i (in_data_i[i]),
      .ready_o(in_ready_o[i]),
      .v_o    (in_v),
      .data_o (in_data),
      .yumi_i (in_yumi)
    );

    // Coordinate is the lowest header field
    assign match = (in_data[cord_width_c-1:0] == loop_cord_p);

    // Foreign flits leave at once while ours wait for room in the output slot
    assign in_yumi   = in_v & (~match | out_slot_ready);
    assign drop_o[i] = in_v & ~match;

    one_slot_fifo #(.width_p(flit_width_c)) out_fifo (
      .clk_i  (clk_i),
      .reset_i(reset_i),
      .v_i    (in_v & match),
      .data_i (in_data),
      .ready_o(out_slot_ready),
      .v_o    (out_v_o[i]),
      .data_o (out_data_o[i]),
      .yumi_i (out_v_o[i] & out_ready_i[i])
    );
  end

endmodule

// File: hdl/test_node_master.sv
`timescale 1ns/1ps

module test_node_master
  import wh_test_pkg::*;
#(
  parameter int num_channels_p  = 2,
  parameter int channel_width_p = 8
)
(
  input  logic                                    clk_i,
  input  logic                                    reset_i,

  input  logic [num_nets_c-1:0]                   en_i,
  input  logic [cord_width_c-1:0]                 dest_cord_i,
  output logic [num_nets_c-1:0]                   error_o,
  output logic [num_nets_c-1:0][31:0]             sent_o,
  output logic [num_nets_c-1:0][31:0]             received_o,

  output logic [num_nets_c-1:0]                   fwd_v_o,
  output logic [num_nets_c-1:0][flit_width_c-1:0] fwd_data_o,
  input  logic [num_nets_c-1:0]                   fwd_ready_i,

  input  logic [num_nets_c-1:0]                   rev_v_i,
  input  logic [num_nets_c-1:0][flit_width_c-1:0] rev_data_i,
  output logic [num_nets_c-1:0]                   rev_ready_o
);

  localparam int data_width_lp = num_channels_p * channel_width_p;

  for (genvar i = 0; i < num_nets_c; i++)
  begin : g_net
    logic                       req_ready;
    logic [flit_width_c-1:0]    req_data;
    logic                       send_accept;
    logic                       resp_v;
    logic [flit_width_c-1:0]    resp_data;
    logic [data_width_lp-1:0]   gen_data;
    logic [data_width_lp-1:0]   check_data;
    logic                       mismatch;
    logic [31:0]                sent_r;
    logic [31:0]                recv_r;
    logic                       error_r;

    // Single-flit packet of payload, zero length and destination
    assign req_data    = {payload_width_c'(gen_data), {len_width_c{1'b0}}, dest_cord_i};
    assign send_accept = en_i[i] & req_ready;

    one_slot_fifo #(.width_p(flit_width_c)) req_out_fifo (
      .clk_i  (clk_i),
      .reset_i(reset_i),
      .v_i    (en_i[i]),
      .data_i (req_data),
      .ready_o(req_ready),
      .v_o    (fwd_v_o[i]),
      .data_o (fwd_data_o[i]),
      .yumi_i (fwd_v_o[i] & fwd_ready_i[i])
    );

    one_slot_fifo #(.width_p(flit_width_c)) resp_in_fifo (
      .clk_i  (clk_i),
      .reset_i(reset_i),
      .v_i    (rev_v_i[i]),
      .data_i (rev_data_i[i]),
      .ready_o(rev_ready_o[i]),
      .v_o    (resp_v),
      .data_o (resp_data),
      .yumi_i (resp_v)
    );

    // Sender side sequence advances only on accepted sends
    test_data_gen #(
      .num_channels_p (num_channels_p),
      .channel_width_p(channel_width_p)
    ) gen_out (
      .clk_i  (clk_i),
      .reset_i(reset_i),
      .yumi_i (send_accept),
      .data_o (gen_data)
    );

    // Same sequence again stepped by returned flits
    test_data_gen #(
      .num_channels_p (num_channels_p),
      .channel_width_p(channel_width_p)
    ) gen_check (
      .clk_i  (clk_i),
      .reset_i(reset_i),
      .yumi_i (resp_v),
      .data_o (check_data)
    );

    // Whole payload field compared so unused upper bits must be zero
    assign mismatch = resp_v &
      (resp_data[flit_width_c-1 -: payload_width_c] != payload_width_c'(check_data));

    always_ff @(posedge clk_i)
    begin
      if (reset_i)
      begin
        sent_r  <= '0;
        recv_r  <= '0;
        error_r <= 1'b0;
      end
      else
      begin
        if (send_accept)
          sent_r <= sent_r + 1'b1;
        if (resp_v)
          recv_r <= recv_r + 1'b1;
        if (mismatch)
          error_r <= 1'b1;
      end
    end

    assign sent_o[i]     = sent_r;
    assign received_o[i] = recv_r;
    assign error_o[i]    = error_r;
  end

endmodule

// File: hdl/test_data_gen.sv
`timescale 1ns/1ps

module test_data_gen #(
  parameter int num_channels_p  = 2,
  parameter int channel_width_p = 8
)
(
  input  logic                                      clk_i,
  input  logic                                      reset_i,
  input  logic                                      yumi_i,
  output logic [num_channels_p*channel_width_p-1:0] data_o
);

  logic [channel_width_p-1:0] cnt_r [num_channels_p];

  for (genvar k = 0; k < num_channels_p; k++)
  begin : g_chan
    // Channel k starts at k so the channels are told apart
    always_ff @(posedge clk_i)
    begin
      if (reset_i)
        cnt_r[k] <= channel_width_p'(k);
      else if (yumi_i)
        cnt_r[k] <= cnt_r[k] + 1'b1;
    end

    assign data_o[k*channel_width_p +: channel_width_p] = cnt_r[k];
  end

endmodule

// File: hdl/one_slot_fifo.sv
`timescale 1ns/1ps

module one_slot_fifo #(
  parameter int width_p = 32
)
(
  input  logic               clk_i,
  input  logic               reset_i,

  input  logic               v_i,
  input  logic [width_p-1:0] data_i,
  output logic               ready_o,

  output logic               v_o,
  output logic [width_p-1:0] data_o,
  input  logic               yumi_i
);

  logic               full_r;
  logic [width_p-1:0] data_r;
  logic               wr_en;

  // Slot can take a new flit when empty or being drained this cycle
  assign ready_o = ~full_r | yumi_i;
  assign wr_en   = v_i & ready_o;

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
      full_r <= 1'b0;
    else if (wr_en)
      full_r <= 1'b1;
    else if (yumi_i)
      full_r <= 1'b0;
  end

  // Flit held in the slot
  always_ff @(posedge clk_i)
  begin
    if (wr_en)
      data_r <= data_i;
  end

  assign v_o    = full_r;
  assign data_o = data_r;

endmodule

// File: hdl/wh_test_pkg.sv
package wh_test_pkg;

  // Link flit as seen on every ready/valid boundary
  localparam int flit_width_c = 32;

  // Header fields with the coordinate in the lowest bits and the length above it
  localparam int cord_width_c = 6;
  localparam int len_width_c  = 4;

  // Whatever is left of the flit above the header
  localparam int payload_width_c = flit_width_c - cord_width_c - len_width_c;

  // Master drives two independent nets
  localparam int num_nets_c = 2;

  // Host register map
  typedef enum logic [2:0] {
    // Per-net enable bits with bit n for net n
    REG_ENABLE = 3'd0,
    // Destination coordinate for all nets
    REG_DEST   = 3'd1,
    // Packets accepted for sending
    REG_SENT0  = 3'd2,
    REG_SENT1  = 3'd3,
    // Packets that came back
    REG_RECV0  = 3'd4,
    REG_RECV1  = 3'd5,
    // Sticky mismatch flags with bit n for net n
    REG_ERROR  = 3'd6
  } reg_addr_e;

endpackage
